/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --timing --assert
TOP        := y86CoreTb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) verif/y86_testdata.hex
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
rtl/y86Pkg.sv
rtl/stageSequencer.sv
rtl/fetchDecode.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/memoryAccess.sv
rtl/y86Core.sv
verif/tbMemory.sv
verif/y86CoreTb.sv

/* rtl/executeUnit.sv */
`timescale 1ns/1ps
module executeUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  y86Pkg::stage_t        stage,
  input  y86Pkg::decodedInstr_t instr,
  input  y86Pkg::word_t         opA,
  input  y86Pkg::word_t         opB,
  output y86Pkg::execResult_t   res,
  output logic                  zeroFlag
);
  import y86Pkg::*;

  logic  isMem;
  logic  isAlu;
  word_t operand2;
  word_t sum;

  assign isMem = instr.isLoad || instr.isStore;
  assign isAlu = instr.isAdd || instr.isSub;

  always_comb
  begin
    if (isMem)
      operand2 = instr.displacement;
    else if (instr.isSub)
      operand2 = ~opB;
    else
      operand2 = opB;
  end

  // Subtract is A + ~B + 1
  assign sum = opA + operand2 + word_t'(instr.isSub);

  always_ff @(posedge clk)
  begin
    if (stage == EXECUTE)
    begin
      res.mar       <= sum;
      res.result    <= instr.isMove ? opB : sum;
      res.storeData <= opB;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      zeroFlag <= 1'b0;
    else if (stage == EXECUTE && isAlu)
      zeroFlag <= (sum == '0);
  end

endmodule

/* rtl/fetchDecode.sv */
`timescale 1ns/1ps
module fetchDecode (
  input  logic                  clk,
  input  logic                  rst,
  input  y86Pkg::stage_t        stage,
  input  y86Pkg::word_t         busIn,
  input  logic                  zeroFlag,
  output y86Pkg::word_t         ip,
  output y86Pkg::decodedInstr_t instr,
  output y86Pkg::opcode_t       opcode
);
  import y86Pkg::*;

  word_t      ir;
  logic [1:0] mod;
  logic       isMem;
  logic       isTwoByte;
  logic       taken;
  word_t      ipNext;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ir <= '0;
      ip <= RESET_IP;
    end
    else
    begin
      if (stage == FETCH)
        ir <= busIn; // Bus answers within the fetch cycle
      if (stage == WRITEBACK)
        ip <= ipNext;
    end
  end

  assign opcode = ir[7:0];
  assign mod    = ir[15:14];

  assign instr.isLoad  = (opcode == OP_LOAD) && (mod == MOD_DISP8);
  assign instr.isStore = (opcode == OP_MOVST) && (mod == MOD_DISP8);
  assign instr.isMove  = (opcode == OP_MOVST) && (mod == MOD_REG);
  assign instr.isAdd   = (opcode == OP_ADD);
  assign instr.isSub   = (opcode == OP_SUB);
  assign instr.isJnz   = (opcode == OP_JNZ);
  assign instr.isHalt  = (opcode == OP_HALT);

  assign instr.rd = ir[10:8];
  assign instr.rs = ir[13:11];

  // Jump distance sits in the second byte, memory displacement in the third
  assign instr.distance     = {{24{ir[15]}}, ir[15:8]};
  assign instr.displacement = {{24{ir[23]}}, ir[23:16]};

  assign isMem     = instr.isLoad || instr.isStore;
  assign isTwoByte = instr.isMove || instr.isAdd || instr.isSub || instr.isJnz;

  always_comb
  begin
    if (isMem)
      instr.length = 2'd3;
    else if (isTwoByte)
      instr.length = 2'd2;
    else
      instr.length = 2'd1; // Halt and unknown opcodes
  end

  assign taken  = instr.isJnz && !zeroFlag;
  assign ipNext = ip + word_t'(instr.length) + (taken ? instr.distance : '0);

  oneClass: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({instr.isLoad, instr.isStore, instr.isMove, instr.isAdd,
              instr.isSub, instr.isJnz, instr.isHalt})
  );

endmodule

/* rtl/memoryAccess.sv */
`timescale 1ns/1ps
module memoryAccess (
  input  logic                  clk,
  input  logic                  rst,
  input  y86Pkg::stage_t        stage,
  input  y86Pkg::decodedInstr_t instr,
  input  y86Pkg::word_t         ip,
  input  y86Pkg::execResult_t   res,
  output y86Pkg::word_t         busA,
  output y86Pkg::word_t         busOut,
  output logic                  busRe,
  output logic                  busWe,
  input  y86Pkg::word_t         busIn,
  output y86Pkg::word_t         loadData
);
  import y86Pkg::*;

  logic loadCycle;

  assign loadCycle = (stage == MEMORY) && instr.isLoad;

  always_comb
  begin
    case (stage)
      FETCH:   busA = ip;
      MEMORY:  busA = res.mar;
      default: busA = '0;
    endcase
  end

  assign busRe  = (stage == FETCH) || loadCycle;
  assign busWe  = (stage == MEMORY) && instr.isStore;
  assign busOut = res.storeData;

  always_ff @(posedge clk)
  begin
    if (rst)
      loadData <= '0;
    else if (loadCycle)
      loadData <= busIn; // Combinational read returns in this cycle
  end

  noBusClash: assert property (
    @(posedge clk) disable iff (rst)
    !(busRe && busWe)
  );

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ps
module registerFile (
  input  logic              clk,
  input  logic              rst,
  input  y86Pkg::regIdx_t   addrA,
  input  y86Pkg::regIdx_t   addrB,
  output y86Pkg::word_t     dataA,
  output y86Pkg::word_t     dataB,
  input  y86Pkg::regWrite_t wr
);
  import y86Pkg::*;

  word_t regs [8];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr.en)
    begin
      regs[wr.idx] <= wr.data;
    end
  end

  // Read ports see the old value during the writeback cycle
  assign dataA = regs[addrA];
  assign dataB = regs[addrB];

endmodule

/* rtl/stageSequencer.sv */
`timescale 1ns/1ps
module stageSequencer (
  input  logic            clk,
  input  logic            rst,
  input  logic            haltSeen,
  output y86Pkg::stage_t  stage,
  output logic            halted
);
  import y86Pkg::*;

  always_ff @(posedge clk)
  begin
    if (rst)
      stage <= FETCH;
    else
    begin
      case (stage)
        FETCH:     stage <= DECODE;
        DECODE:    stage <= haltSeen ? HALTED : EXECUTE; // Halt stops the ring here
        EXECUTE:   stage <= MEMORY;
        MEMORY:    stage <= WRITEBACK;
        WRITEBACK: stage <= FETCH;
        HALTED:    stage <= HALTED;
        default:   stage <= FETCH;
      endcase
    end
  end

  assign halted = (stage == HALTED);

  // Only reset brings the core out of the halted state
  haltIsFinal: assert property (
    @(posedge clk) disable iff (rst)
    stage == HALTED |=> stage == HALTED
  );

endmodule

/* rtl/y86Core.sv */
`timescale 1ns/1ps
module y86Core (
  input  logic            clk,
  input  logic            rst,
  output y86Pkg::word_t   busA,
  output y86Pkg::word_t   busOut,
  input  y86Pkg::word_t   busIn,
  output logic            busWe,
  output logic            busRe,
  output y86Pkg::opcode_t currentOpcode,
  output logic            halted
);
  import y86Pkg::*;

  stage_t        stage;
  word_t         ip;
  decodedInstr_t instr;
  logic          zeroFlag;
  regIdx_t       addrA;
  regIdx_t       addrB;
  word_t         dataA;
  word_t         dataB;
  execResult_t   res;
  word_t         loadData;
  regWrite_t     wr;

  stageSequencer uSeq (
    .clk, .rst, .haltSeen(instr.isHalt), .stage, .halted
  );

  fetchDecode uFetch (
    .clk, .rst, .stage, .busIn, .zeroFlag, .ip, .instr, .opcode(currentOpcode)
  );

  // Memory forms address from the base register
  assign addrA = (instr.isLoad || instr.isStore) ? BASE_REG : instr.rd;
  assign addrB = instr.rs;

  registerFile uRegs (
    .clk, .rst, .addrA, .addrB, .dataA, .dataB, .wr
  );

  executeUnit uExec (
    .clk, .rst, .stage, .instr, .opA(dataA), .opB(dataB), .res, .zeroFlag
  );

  memoryAccess uMem (
    .clk, .rst, .stage, .instr, .ip, .res,
    .busA, .busOut, .busRe, .busWe, .busIn, .loadData
  );

  // A load writes rs, everything else writes rd
  assign wr.en   = (stage == WRITEBACK) &&
                   (instr.isMove || instr.isAdd || instr.isSub || instr.isLoad);
  assign wr.idx  = instr.isLoad ? instr.rs : instr.rd;
  assign wr.data = instr.isLoad ? loadData : res.result;

endmodule

/* rtl/y86Pkg.sv */
package y86Pkg;

  typedef logic [31:0] word_t;   // Data, address or register value
  typedef logic [2:0]  regIdx_t;
  typedef logic [7:0]  opcode_t; // First instruction byte

  // One-hot encoding so each stage value is also the stage token
  typedef enum logic [5:0] {
    FETCH     = 6'b000001,
    DECODE    = 6'b000010,
    EXECUTE   = 6'b000100,
    MEMORY    = 6'b001000,
    WRITEBACK = 6'b010000,
    HALTED    = 6'b100000
  } stage_t;

  localparam opcode_t OP_ADD   = 8'h01;
  localparam opcode_t OP_SUB   = 8'h29;
  localparam opcode_t OP_MOVST = 8'h89; // Register move or store, told apart by mod
  localparam opcode_t OP_LOAD  = 8'h8B;
  localparam opcode_t OP_JNZ   = 8'h75;
  localparam opcode_t OP_HALT  = 8'hF4;

  localparam logic [1:0] MOD_DISP8 = 2'd1;
  localparam logic [1:0] MOD_REG   = 2'd3;

  localparam regIdx_t BASE_REG = 3'd6;  // Base for every memory address
  localparam word_t   RESET_IP = 32'h0;

  typedef struct packed {
    logic       isLoad;
    logic       isStore;
    logic       isMove;
    logic       isAdd;
    logic       isSub;
    logic       isJnz;
    logic       isHalt;
    regIdx_t    rd;
    regIdx_t    rs;
    word_t      displacement;
    word_t      distance;
    logic [1:0] length;
  } decodedInstr_t;

  typedef struct packed {
    word_t mar;
    word_t result;
    word_t storeData;
  } execResult_t;

  typedef struct packed {
    logic    en;
    regIdx_t idx;
    word_t   data;
  } regWrite_t;

endpackage

/* verif/tbMemory.sv */
`timescale 1ns/1ps
module tbMemory (
  input  logic          clk,
  input  y86Pkg::word_t addr,
  input  y86Pkg::word_t wrData,
  input  logic          we,
  output y86Pkg::word_t rdData
);
  import y86Pkg::*;

  word_t      testData [128]; // Program image, store records and instruction count
  logic [7:0] mem [256];
  logic [7:0] idx;

  initial
  begin
    for (int i = 0; i < 128; i++)
    begin
      testData[i] = '0;
    end
    $readmemh("verif/y86_testdata.hex", testData);
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = testData[i / 4][8 * (i % 4) +: 8];
    end
  end

  assign idx = addr[7:0];

  // Little-endian word that wraps at the top of the 256-byte space
  assign rdData = {mem[8'(idx + 8'd3)], mem[8'(idx + 8'd2)], mem[8'(idx + 8'd1)], mem[idx]};

  always @(posedge clk)
  begin
    if (we)
    begin
      for (int i = 0; i < 4; i++)
      begin
        mem[8'(idx + 8'(i))] <= wrData[8 * i +: 8];
      end
    end
  end

endmodule

/* verif/y86CoreTb.sv */
`timescale 1ns/1ps
module y86CoreTb;
  import y86Pkg::*;

  logic       clk;
  logic       rst;
  word_t      busA;
  word_t      busOut;
  word_t      busIn;
  logic       busWe;
  logic       busRe;
  opcode_t    currentOpcode;
  logic       halted;

  logic [7:0] modelMem [256];    // Reference copy of memory for the ISA model
  word_t      modelRegs [8];
  word_t      modelIp;
  logic       modelZf;
  logic       modelHalted;
  int         modelCount;

  word_t      expAddr [$];
  word_t      expData [$];
  int         instrCount;
  int         cycle;
  int         cycleLimit;
  int         haltCycle;
  int         settleCount;
  logic       haltDone;
  logic       timedOut;
  logic       finished;
  int         storeErrors;
  int         fetchErrors;
  int         haltErrors;
  int         busErrors;

  y86Core dut (
    .clk, .rst, .busA, .busOut, .busIn, .busWe, .busRe, .currentOpcode, .halted
  );

  tbMemory memory (.clk, .addr(busA), .wrData(busOut), .we(busWe), .rdData(busIn));

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic word_t readModelWord(logic [7:0] a);
    return {modelMem[8'(a + 8'd3)], modelMem[8'(a + 8'd2)], modelMem[8'(a + 8'd1)], modelMem[a]};
  endfunction

  // Executes the instruction at modelIp and moves modelIp to the next fetch address
  task automatic stepModel();
    logic [7:0] p;
    opcode_t    op;
    logic [7:0] modrm;
    logic [7:0] imm;
    regIdx_t    rd;
    regIdx_t    rs;
    word_t      addr;
    word_t      sum;
    word_t      next;
    p     = modelIp[7:0];
    op    = modelMem[p];
    modrm = modelMem[8'(p + 8'd1)];
    imm   = modelMem[8'(p + 8'd2)];
    rs    = modrm[5:3];
    rd    = modrm[2:0];
    addr  = modelRegs[BASE_REG] + {{24{imm[7]}}, imm};
    next  = modelIp + 32'd1; // Anything unknown is a one-byte no-op
    case (op)
      OP_LOAD:
        if (modrm[7:6] == MOD_DISP8)
        begin
          modelRegs[rs] = readModelWord(addr[7:0]);
          next = modelIp + 32'd3;
        end
      OP_MOVST:
        if (modrm[7:6] == MOD_DISP8)
        begin
          for (int i = 0; i < 4; i++)
          begin
            modelMem[8'(addr[7:0] + 8'(i))] = modelRegs[rs][8 * i +: 8];
          end
          next = modelIp + 32'd3;
        end
        else if (modrm[7:6] == MOD_REG)
        begin
          modelRegs[rd] = modelRegs[rs];
          next = modelIp + 32'd2;
        end
      OP_ADD, OP_SUB:
      begin
        sum = (op == OP_ADD) ? modelRegs[rd] + modelRegs[rs] : modelRegs[rd] - modelRegs[rs];
        modelRegs[rd] = sum;
        modelZf = (sum == '0);
        next = modelIp + 32'd2;
      end
      OP_JNZ:
      begin
        next = modelIp + 32'd2;
        if (!modelZf)
          next = next + {{24{modrm[7]}}, modrm}; // Distance counts from the next instruction
      end
      OP_HALT:
      begin
        next = modelIp;
        modelHalted = 1'b1;
      end
      default:
        next = modelIp + 32'd1;
    endcase
    if (!modelHalted)
      modelCount++;
    modelIp = next;
  endtask

  task automatic loadExpectations();
    int records;
    for (int w = 0; w < 64; w++)
    begin
      for (int b = 0; b < 4; b++)
      begin
        modelMem[4 * w + b] = memory.testData[w][8 * b +: 8];
      end
    end
    for (int r = 0; r < 8; r++)
    begin
      modelRegs[r] = '0;
    end
    records = memory.testData[64];
    for (int k = 0; k < records; k++)
    begin
      expAddr.push_back(memory.testData[65 + 2 * k]);
      expData.push_back(memory.testData[66 + 2 * k]);
    end
    instrCount = memory.testData[127];
    cycleLimit = 5 * instrCount + 50;
    haltCycle  = 5 * instrCount + 2; // Halt decodes after its fetch, the flag follows a cycle later
  endtask

  task automatic checkStore(word_t addr, word_t data);
    word_t ea;
    word_t ed;
    if (expAddr.size() == 0)
    begin
      $display("[ERROR] %0t: unexpected store of %h to %h", $time, data, addr);
      storeErrors++;
    end
    else
    begin
      ea = expAddr.pop_front();
      ed = expData.pop_front();
      if (addr !== ea || data !== ed)
      begin
        $display("[ERROR] %0t: store %h to %h, expected %h to %h", $time, data, addr, ed, ea);
        storeErrors++;
      end
    end
  endtask

  task automatic checkFetch(word_t got, word_t expected);
    if (got !== expected)
    begin
      $display("[ERROR] %0t: fetch from %h, expected %h", $time, got, expected);
      fetchErrors++;
    end
  endtask

  task automatic checkOpcode(opcode_t got, opcode_t expected);
    if (got !== expected)
    begin
      $display("[ERROR] %0t: opcode %h at halt, expected %h", $time, got, expected);
      haltErrors++;
    end
  endtask

  task automatic checkCycle();
    if (cycle % 5 == 0 && !modelHalted)
    begin
      if (busRe !== 1'b1)
      begin
        $display("Fetch cycle %0d has no bus read strobe", cycle);
        busErrors++;
      end
      checkFetch(busA, modelIp);
      stepModel();
    end
    if (haltDone && (busRe || busWe))
    begin
      $display("Bus strobe seen in cycle %0d after the core halted", cycle);
      busErrors++;
    end
    else if (busWe)
      checkStore(busA, busOut);
    if (halted && !haltDone)
    begin
      haltDone = 1'b1;
      if (cycle != haltCycle)
      begin
        $display("[ERROR] %0t: halted rose in cycle %0d, expected %0d", $time, cycle, haltCycle);
        haltErrors++;
      end
      checkOpcode(currentOpcode, OP_HALT);
      if (modelCount != instrCount)
      begin
        $display("Model ran %0d instructions but the data file expects %0d", modelCount,
                 instrCount);
        haltErrors++;
      end
    end
  endtask

  initial
  begin
    rst         = 1'b1;
    cycle       = 0;
    settleCount = 0;
    haltDone    = 1'b0;
    timedOut    = 1'b0;
    finished    = 1'b0;
    modelIp     = RESET_IP;
    modelZf     = 1'b0;
    modelHalted = 1'b0;
    modelCount  = 0;
    storeErrors = 0;
    fetchErrors = 0;
    haltErrors  = 0;
    busErrors   = 0;
    repeat (8) @(posedge clk);
    loadExpectations();
    rst <= 1'b0;
    while (!finished)
    begin
      @(negedge clk);
      checkCycle();
      cycle++;
      if (haltDone)
        settleCount++;
      if (settleCount > 10) // Watch the bus stay quiet for a while after halt
        finished = 1'b1;
      else if (cycle >= cycleLimit)
      begin
        $display("Timeout because the core did not halt within %0d cycles", cycleLimit);
        timedOut = 1'b1;
        finished = 1'b1;
      end
    end
    if (expData.size() != 0)
    begin
      $display("%0d expected stores never appeared on the bus", expData.size());
      storeErrors += expData.size();
    end
    $display("Errors: store %0d, fetch %0d, halt %0d, bus %0d", storeErrors, fetchErrors,
             haltErrors, busErrors);
    if (timedOut || storeErrors + fetchErrors + haltErrors + busErrors != 0)
      $display("Test failed");
    else
      $display("Test completed successfully");
    $finish;
  end

endmodule

/* verif/y86_testdata.hex */
// Words 00-3F: program image as little-endian words; word 40: number of store records
// Words 41 on: store address and data pairs; word 7F: instructions executed before halt
@00
8B404E8B 5E8B4456
4C668B48 5E89E301
89E32960 646E89DD
89647E8B D129687E
756C4E89 00F490F9
@10
00000005 00000001
12345678 00001111
@40
00000008
00000060 12346789
00000064 12345678
00000068 12345678
0000006C 00000004
0000006C 00000003
0000006C 00000002
0000006C 00000001
0000006C 00000000
@7F
0000001B
